// ==== decode_ctrl.sv ====
/* Prefix and instruction consumption */
module decode_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  queue_pkg::window_t queue_bytes,
    input  queue_pkg::count_t  queue_count,
    input  x86_pkg::op_class_e op_class,
    input  queue_pkg::count_t  body_len,
    input  logic               insn_ready,
    output queue_pkg::count_t  consume_count,
    output queue_pkg::count_t  prefix_count,
    output logic               opsize,
    output x86_pkg::insn_t     insn,
    output logic               insn_valid
);
    import queue_pkg::*;
    import x86_pkg::*;

    // Per-cycle decision on the queue head.
    typedef enum logic [1:0] {
        ACT_IDLE,
        ACT_PREFIX,
        ACT_INSN
    } action_e;

    action_e    act;
    logic [7:0] head;
    logic       out_free;   // Output register empty or draining.
    logic       lock_q;
    logic       rep_q;
    insn_t      insn_next;

    assign head     = queue_bytes[0];
    assign out_free = !insn_valid || insn_ready;

    always_comb begin
        act = ACT_IDLE;
        if (!flush && out_free && queue_count != '0) begin
            if (is_prefix(head))
                act = ACT_PREFIX;          // One prefix per cycle.
            else if (queue_count >= body_len)
                act = ACT_INSN;            // Whole body present.
        end
    end

    assign consume_count = (act == ACT_INSN)   ? body_len :
                           (act == ACT_PREFIX) ? count_t'(1) : '0;

    always_comb begin
        insn_next = '0;
        for (int i = 0; i < MAX_BODY_BYTES; i++) begin
            if (i < int'(body_len))
                insn_next.body[i] = queue_bytes[i];  // Bytes past the body stay zero.
        end
        insn_next.op_class     = op_class;
        insn_next.body_len     = body_len;
        insn_next.prefix_count = prefix_count;
        insn_next.opsize       = opsize;
        insn_next.lock         = lock_q;
        insn_next.rep          = rep_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prefix_count <= '0;
            opsize       <= 1'b0;
            lock_q       <= 1'b0;
            rep_q        <= 1'b0;
        end else if (flush || act == ACT_INSN) begin
            prefix_count <= '0;  // Prefixes belong to this instruction only.
            opsize       <= 1'b0;
            lock_q       <= 1'b0;
            rep_q        <= 1'b0;
        end else if (act == ACT_PREFIX) begin
            prefix_count <= prefix_count + 1'b1;
            if (head == PFX_OPSIZE)
                opsize <= 1'b1;
            if (head == PFX_LOCK)
                lock_q <= 1'b1;
            if (head == PFX_REPNE || head == PFX_REP)
                rep_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            insn_valid <= 1'b0;
        else if (flush)
            insn_valid <= 1'b0;  // Pending record dropped.
        else if (act == ACT_INSN)
            insn_valid <= 1'b1;
        else if (insn_ready)
            insn_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (act == ACT_INSN)
            insn <= insn_next;
    end

    // A stalled record holds and the queue is left alone.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n || flush)
        insn_valid && !insn_ready |=>
            insn_valid && $stable(insn) && ($past(consume_count) == '0));

endmodule

// ==== decode_regs.sv ====
/* Shifting decode byte queue */
module decode_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  queue_pkg::fetch_t  fetch,
    input  queue_pkg::count_t  consume_count,
    input  queue_pkg::count_t  prefix_count,
    output queue_pkg::count_t  fetch_accept,
    output queue_pkg::window_t queue_bytes,
    output queue_pkg::count_t  queue_count
);
    import queue_pkg::*;

    count_t     survive_count;  // Bytes left after consumption.
    count_t     room_queue;     // Free queue slots.
    count_t     room_insn;      // Room under the length limit.
    count_t     offer;
    count_t     accepted;       // Bytes actually taken this cycle.
    logic [4:0] total_count;    // Prefixes plus queued bytes.
    logic       quiet_q;        // Blocks fetch for one cycle.
    window_t    shifted;
    window_t    survivors;
    window_t    incoming;
    window_t    queue_next;

    assign survive_count = queue_count - consume_count;
    assign total_count   = 5'(prefix_count) + 5'(queue_count);

    assign room_queue = count_t'(QUEUE_BYTES) - queue_count;
    assign room_insn  = (total_count < 5'(MAX_INSN_BYTES)) ?
                        count_t'(5'(MAX_INSN_BYTES) - total_count) : '0;

    assign offer        = (room_queue < room_insn) ? room_queue : room_insn;
    assign fetch_accept = (flush || quiet_q) ? '0 : offer;
    assign accepted     = (fetch.count < fetch_accept) ? fetch.count : fetch_accept;

    // Drop consumed bytes from the head.
    assign shifted = queue_bytes >> {consume_count, 3'b000};

    always_comb begin
        survivors = '0;
        for (int i = 0; i < QUEUE_BYTES; i++) begin
            if (i < int'(survive_count))
                survivors[i] = shifted[i];  // Keep only live bytes.
        end
    end

    always_comb begin
        incoming = '0;
        for (int i = 0; i < FETCH_BYTES; i++) begin
            if (i < int'(accepted))
                incoming[i] = fetch.data[i];  // Accepted low bytes only.
        end
    end

    // New bytes land right after the survivors.
    assign queue_next = survivors | (incoming << {survive_count, 3'b000});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            queue_count <= '0;
            quiet_q     <= 1'b1;  // Quiet cycle out of reset.
        end else if (flush) begin
            queue_count <= '0;
            quiet_q     <= 1'b1;  // Quiet cycle after flush.
        end else begin
            queue_count <= survive_count + accepted;
            quiet_q     <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        queue_bytes <= flush ? '0 : queue_next;  // Bytes past the count stay zero.
    end

    // Controller never consumes bytes that are not queued.
    a_consume_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        consume_count <= queue_count);

    // Intake stays within the offer and the 15-byte budget holds.
    a_accept_in_offer: assert property (@(posedge clk) disable iff (!rst_n)
        !flush |=> (queue_count <= $past(survive_count + fetch_accept)) &&
                   (5'(queue_count) + 5'(prefix_count) <= 5'(MAX_INSN_BYTES)));

endmodule

// ==== decode_top.sv ====
/* Instruction decoder front */
module decode_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  queue_pkg::fetch_t fetch,
    input  logic              insn_ready,
    output queue_pkg::count_t fetch_accept,
    output x86_pkg::insn_t    insn,
    output logic              insn_valid
);
    import queue_pkg::*;
    import x86_pkg::*;

    window_t   queue_bytes;    // Head-aligned window.
    count_t    queue_count;
    count_t    consume_count;
    count_t    prefix_count;
    count_t    body_len;
    op_class_e op_class;
    logic      opsize;         // Registered 66h flag.

    decode_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .fetch         (fetch),
        .consume_count (consume_count),
        .prefix_count  (prefix_count),
        .fetch_accept  (fetch_accept),
        .queue_bytes   (queue_bytes),
        .queue_count   (queue_count)
    );

    opcode_length u_length (
        .body     (queue_bytes),
        .opsize   (opsize),
        .op_class (op_class),
        .body_len (body_len)
    );

    decode_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .queue_bytes   (queue_bytes),
        .queue_count   (queue_count),
        .op_class      (op_class),
        .body_len      (body_len),
        .insn_ready    (insn_ready),
        .consume_count (consume_count),
        .prefix_count  (prefix_count),
        .opsize        (opsize),
        .insn          (insn),
        .insn_valid    (insn_valid)
    );

endmodule

// ==== opcode_length.sv ====
/* Opcode length measurement */
module opcode_length (
    input  queue_pkg::window_t body,
    input  logic               opsize,
    output x86_pkg::op_class_e op_class,
    output queue_pkg::count_t  body_len
);
    import queue_pkg::*;
    import x86_pkg::*;

    logic [7:0] opcode;
    logic [7:0] modrm;
    logic [7:0] sib;
    logic [1:0] mode;       // ModRM mod field.
    logic [2:0] rm;
    logic [2:0] sib_base;
    logic       has_modrm;
    logic       has_sib;
    count_t     disp_len;
    count_t     modrm_len;  // ModRM, SIB and displacement.
    count_t     imm_len;

    assign opcode   = body[0];
    assign modrm    = body[1];
    assign sib      = body[2];
    assign mode     = modrm[7:6];
    assign rm       = modrm[2:0];
    assign sib_base = sib[2:0];

    always_comb begin
        op_class = OP_UNDEF;
        case (opcode) inside
            [8'h40:8'h5F], 8'h90, 8'hC3:   op_class = OP_SIMPLE;  // INC/DEC/PUSH/POP, NOP, RET.
            [8'hB0:8'hB7], [8'h70:8'h7F],
            8'hEB:                         op_class = OP_IMM8;    // MOV r8, Jcc, JMP short.
            [8'hB8:8'hBF], 8'hE8, 8'hE9:   op_class = OP_IMMV;    // MOV r32, CALL, JMP near.
            [8'h88:8'h8B]:                 op_class = OP_MODRM;   // MOV forms.
            8'h83:                         op_class = OP_MODRM_IMM8;
            8'h81, 8'hC7:                  op_class = OP_MODRM_IMMV;
            default: begin
                if (opcode[7:6] == 2'b00) begin  // ALU block 00-3F.
                    case (opcode[2:0])
                        3'd0, 3'd1, 3'd2, 3'd3: op_class = OP_MODRM;
                        3'd4:                   op_class = OP_IMM8;   // AL, imm8.
                        3'd5:                   op_class = OP_IMMV;   // eAX, imm.
                        default:                op_class = OP_UNDEF;  // Includes 0F.
                    endcase
                end
            end
        endcase
    end

    assign has_modrm = (op_class == OP_MODRM) || (op_class == OP_MODRM_IMM8) ||
                       (op_class == OP_MODRM_IMMV);
    assign has_sib   = (mode != 2'b11) && (rm == 3'd4);

    always_comb begin
        disp_len = '0;
        case (mode)
            2'b00: begin
                if (rm == 3'd5 || (has_sib && sib_base == 3'd5))
                    disp_len = 4'd4;  // disp32 without base.
            end
            2'b01:   disp_len = 4'd1;
            2'b10:   disp_len = 4'd4;
            default: disp_len = '0;   // Register operand.
        endcase
    end

    assign modrm_len = 4'd1 + count_t'(has_sib) + disp_len;

    always_comb begin
        case (op_class)
            OP_IMM8, OP_MODRM_IMM8: imm_len = 4'd1;
            OP_IMMV, OP_MODRM_IMMV: imm_len = opsize ? 4'd2 : 4'd4;  // 66h shrinks it.
            default:                imm_len = '0;
        endcase
    end

    assign body_len = 4'd1 + (has_modrm ? modrm_len : '0) + imm_len;

endmodule

// ==== project.f ====
queue_pkg.sv
x86_pkg.sv
decode_regs.sv
opcode_length.sv
decode_ctrl.sv
decode_top.sv
tb_clock_gen.sv
tb_decode.sv

// ==== queue_pkg.sv ====
/* Byte queue geometry and fetch beat */
package queue_pkg;

    localparam int QUEUE_BYTES    = 12;  // Undecoded bytes held.
    localparam int FETCH_BYTES    = 8;   // Widest fetch beat.
    localparam int MAX_INSN_BYTES = 15;  // Architectural limit, prefixes included.
    localparam int COUNT_W        = 4;   // Wide enough for any byte count here.

    // Byte count used on every queue-side port.
    typedef logic [COUNT_W-1:0] count_t;

    // Queue window, byte 0 is the head.
    typedef logic [QUEUE_BYTES-1:0][7:0] window_t;

    // One fetch beat. Only the low count bytes are valid.
    typedef struct packed {
        logic [FETCH_BYTES-1:0][7:0] data;  // Byte 0 is the earliest.
        count_t                      count; // Valid low bytes.
    } fetch_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the decoder regression with Verilator.
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_decode -o tb_decode_sim
./obj_dir/tb_decode_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Regression passed" sim.log

// ==== tb_clock_gen.sv ====
/* Testbench clock and reset */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;           // Released after three cycles.
    end

endmodule

// ==== tb_decode.sv ====
/* Decoder front regression */
module tb_decode;
    timeunit 1ns;
    timeprecision 1ps;

    import queue_pkg::*;
    import x86_pkg::*;

    localparam int N_FIRST     = 150;  // Stream cut short by the flush.
    localparam int N_SECOND    = 150;  // Stream fed after the flush.
    localparam int CYCLE_LIMIT = 40 * (N_FIRST + N_SECOND) + 200;

    logic       clk;
    logic       rst_n;
    logic       flush;
    fetch_t     fetch;
    logic       insn_ready;
    count_t     fetch_accept;
    insn_t      insn;
    logic       insn_valid;

    logic [7:0] gen_bytes[$];
    insn_t      gen_recs[$];
    logic [7:0] stream_b[$];
    insn_t      exp_b[$];
    logic [7:0] stream[$];     // Bytes being fed.
    insn_t      exp_q[$];      // Records still due.
    int         ptr;           // Next stream byte to offer.
    int         popped;
    int         cycles;
    int         errors;
    int         checks;
    logic       second_phase;
    logic       quiet_check;   // Next edge closes a quiet cycle.
    logic       held_valid;
    insn_t      held_insn;

    tb_clock_gen clock0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch        (fetch),
        .insn_ready   (insn_ready),
        .fetch_accept (fetch_accept),
        .insn         (insn),
        .insn_valid   (insn_valid)
    );

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected=%0h actual=%0h", name, expected, actual);
        end
    endtask

    function automatic logic legacy_prefix(input logic [7:0] b);
        return b inside {8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65,
                         8'h66, 8'h67, 8'hF0, 8'hF2, 8'hF3};
    endfunction

    function automatic op_class_e ref_class(input logic [7:0] op);
        op_class_e c;
        c = OP_UNDEF;
        if ((op >= 8'h40 && op <= 8'h5F) || op == 8'h90 || op == 8'hC3)
            c = OP_SIMPLE;
        else if ((op >= 8'hB0 && op <= 8'hB7) || (op >= 8'h70 && op <= 8'h7F) ||
                 op == 8'hEB || (op < 8'h40 && op[2:0] == 3'd4))
            c = OP_IMM8;
        else if ((op >= 8'hB8 && op <= 8'hBF) || op == 8'hE8 || op == 8'hE9 ||
                 (op < 8'h40 && op[2:0] == 3'd5))
            c = OP_IMMV;
        else if ((op < 8'h40 && op[2:0] < 3'd4) || (op >= 8'h88 && op <= 8'h8B))
            c = OP_MODRM;
        else if (op == 8'h83)
            c = OP_MODRM_IMM8;
        else if (op == 8'h81 || op == 8'hC7)
            c = OP_MODRM_IMMV;
        return c;
    endfunction

    // Expected record for the instruction at the start of raw.
    function automatic insn_t ref_insn(input logic [15:0][7:0] raw);
        insn_t      r;
        int         p;
        int         len;
        logic [7:0] op;
        logic [7:0] m;
        logic [7:0] s;
        op_class_e  c;
        r = '0;
        p = 0;
        while (p < 4 && legacy_prefix(raw[p])) begin
            r.opsize = r.opsize | (raw[p] == 8'h66);
            r.lock   = r.lock | (raw[p] == 8'hF0);
            r.rep    = r.rep | (raw[p] == 8'hF2) | (raw[p] == 8'hF3);
            p++;
        end
        op  = raw[p];
        m   = raw[p + 1];
        s   = raw[p + 2];
        c   = ref_class(op);
        len = 1;
        if (c == OP_MODRM || c == OP_MODRM_IMM8 || c == OP_MODRM_IMMV) begin
            len += 1;
            if (m[7:6] != 2'b11 && m[2:0] == 3'd4)
                len += 1;                                    // SIB.
            if (m[7:6] == 2'b00 && (m[2:0] == 3'd5 || (m[2:0] == 3'd4 && s[2:0] == 3'd5)))
                len += 4;
            else if (m[7:6] == 2'b01)
                len += 1;
            else if (m[7:6] == 2'b10)
                len += 4;
        end
        if (c == OP_IMM8 || c == OP_MODRM_IMM8)
            len += 1;
        if (c == OP_IMMV || c == OP_MODRM_IMMV)
            len += r.opsize ? 2 : 4;
        for (int i = 0; i < len; i++)
            r.body[i] = raw[p + i];
        r.op_class     = c;
        r.body_len     = 4'(len);
        r.prefix_count = 4'(p);
        return r;
    endfunction

    function automatic logic [7:0] pick_prefix();
        case ($urandom_range(0, 12))
            0:       return 8'h67;
            1:       return 8'hF0;
            2:       return 8'hF2;
            3:       return 8'hF3;
            4:       return 8'h26;
            5:       return 8'h2E;
            6:       return 8'h36;
            7:       return 8'h3E;
            8:       return 8'h64;
            9:       return 8'h65;
            default: return 8'h66;  // Opsize weighted up.
        endcase
    endfunction

    function automatic logic [7:0] pick_opcode(input int cls);
        int pick;
        pick = $urandom_range(0, 3);
        case (cls)
            0: case (pick)
                0:       return 8'h90;
                1:       return 8'hC3;
                default: return 8'h40 + 8'($urandom_range(0, 31));
            endcase
            1: case (pick)
                0:       return 8'hB0 + 8'($urandom_range(0, 7));
                1:       return 8'h70 + 8'($urandom_range(0, 15));
                2:       return 8'hEB;
                default: return {2'b00, 3'($urandom_range(0, 7)), 3'd4};
            endcase
            2: case (pick)
                0:       return 8'hB8 + 8'($urandom_range(0, 7));
                1:       return 8'hE8;
                2:       return 8'hE9;
                default: return {2'b00, 3'($urandom_range(0, 7)), 3'd5};
            endcase
            3: if (pick < 2)
                return 8'h88 + 8'($urandom_range(0, 3));
            else
                return {2'b00, 3'($urandom_range(0, 7)), 3'($urandom_range(0, 3))};
            4: return 8'h83;
            5: return pick[0] ? 8'h81 : 8'hC7;
            default: case ($urandom_range(0, 7))  // Undefined, never a prefix.
                0:       return 8'h0F;
                1:       return 8'h06;
                2:       return 8'h27;
                3:       return 8'h62;
                4:       return 8'h8C;
                5:       return 8'hD8;
                6:       return 8'hF4;
                default: return 8'hFF;
            endcase
        endcase
    endfunction

    task automatic gen_insn();
        logic [15:0][7:0] raw;
        int               np;
        insn_t            rec;
        raw = '0;
        np  = $urandom_range(0, 3);
        for (int i = 0; i < np; i++)
            raw[i] = pick_prefix();
        raw[np] = pick_opcode($urandom_range(0, 6));
        for (int i = np + 1; i < 16; i++)
            raw[i] = 8'($urandom);  // ModRM, SIB, disp and imm bytes.
        rec = ref_insn(raw);
        for (int i = 0; i < np + int'(rec.body_len); i++)
            gen_bytes.push_back(raw[i]);
        gen_recs.push_back(rec);
    endtask

    // Fetch source and flush control.
    always @(posedge clk) begin
        int     step;
        int     cnt;
        fetch_t beat;
        if (rst_n) begin
            step = (fetch.count < fetch_accept) ? int'(fetch.count) : int'(fetch_accept);
            ptr  = ptr + step;
            quiet_check <= 1'b0;
            if (flush) begin
                stream       = stream_b;  // Restart on an instruction boundary.
                exp_q        = exp_b;
                ptr          = 0;
                second_phase = 1'b1;
                quiet_check <= 1'b1;
                flush       <= 1'b0;
            end else if (!second_phase && popped >= N_FIRST / 2) begin
                flush <= 1'b1;
            end
            cnt = $urandom_range(0, FETCH_BYTES);
            if (cnt > stream.size() - ptr)
                cnt = stream.size() - ptr;
            for (int i = 0; i < FETCH_BYTES; i++)
                beat.data[i] = (i < cnt) ? stream[ptr + i] : 8'($urandom);
            beat.count = count_t'(cnt);
            fetch      <= beat;
            insn_ready <= ($urandom_range(0, 3) != 0);
        end
    end

    // Output comparison.
    always @(posedge clk) begin
        insn_t want;
        string tag;
        if (rst_n && !flush) begin
            if (int'(fetch_accept) > QUEUE_BYTES - int'(dut0.u_regs.queue_count)) begin
                errors++;
                $display("fetch_accept of %0d bytes is more than the free queue space",
                         fetch_accept);
            end
            if (quiet_check) begin
                compare("quiet insn_valid", 128'(0), 128'(insn_valid));
                compare("quiet fetch_accept", 128'(0), 128'(fetch_accept));
                compare("quiet queue_count", 128'(0), 128'(dut0.u_regs.queue_count));
            end
            if (held_valid) begin
                compare("held insn_valid", 128'(1), 128'(insn_valid));
                compare("held record", 128'(held_insn), 128'(insn));
            end
            if (insn_valid && insn_ready) begin
                tag = $sformatf("%s insn %0d", second_phase ? "second" : "first", popped);
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Decoder sent a record when none was due (%s)", tag);
                end else begin
                    want = exp_q.pop_front();
                    compare({tag, " body"}, 128'(want.body), 128'(insn.body));
                    compare({tag, " class"}, 128'(want.op_class), 128'(insn.op_class));
                    compare({tag, " body_len"}, 128'(want.body_len), 128'(insn.body_len));
                    compare({tag, " prefixes"}, 128'(want.prefix_count),
                            128'(insn.prefix_count));
                    compare({tag, " flags"}, 128'({want.opsize, want.lock, want.rep}),
                            128'({insn.opsize, insn.lock, insn.rep}));
                    popped <= popped + 1;
                end
            end
            held_valid <= insn_valid && !insn_ready;
            held_insn  <= insn;
        end else begin
            held_valid <= 1'b0;
        end
    end

    initial begin
        flush        = 1'b0;
        fetch        = '0;
        insn_ready   = 1'b0;
        ptr          = 0;
        popped       = 0;
        cycles       = 0;
        errors       = 0;
        checks       = 0;
        second_phase = 1'b0;
        quiet_check  = 1'b1;  // Quiet cycle after reset too.
        held_valid   = 1'b0;
        held_insn    = '0;
        void'($urandom(32'h265616a2));
        repeat (N_FIRST) gen_insn();
        stream = gen_bytes;
        exp_q  = gen_recs;
        gen_bytes.delete();
        gen_recs.delete();
        repeat (N_SECOND) gen_insn();
        stream_b = gen_bytes;
        exp_b    = gen_recs;

        while (!(second_phase && exp_q.size() == 0) && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("Timeout after %0d cycles with %0d records still due", cycles,
                     exp_q.size());
        end else begin
            repeat (20) @(negedge clk);  // Catch any stray record.
            compare("bytes fed", 128'(stream.size()), 128'(ptr));
        end
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== x86_pkg.sv ====
/* x86 opcode classes and decoded record */
package x86_pkg;

    localparam int MAX_BODY_BYTES = 11;  // Opcode, ModRM, SIB, disp32, imm32.

    // Length classes of the supported one-byte opcodes.
    typedef enum logic [2:0] {
        OP_SIMPLE,      // Opcode only.
        OP_IMM8,        // Opcode and imm8.
        OP_IMMV,        // Opcode and imm16/imm32.
        OP_MODRM,       // Opcode and ModRM form.
        OP_MODRM_IMM8,  // ModRM form and imm8.
        OP_MODRM_IMMV,  // ModRM form and imm16/imm32.
        OP_UNDEF        // Outside the subset, length one.
    } op_class_e;

    localparam logic [7:0] PFX_OPSIZE = 8'h66;
    localparam logic [7:0] PFX_ADSIZE = 8'h67;  // Counted only.
    localparam logic [7:0] PFX_LOCK   = 8'hF0;
    localparam logic [7:0] PFX_REPNE  = 8'hF2;
    localparam logic [7:0] PFX_REP    = 8'hF3;
    localparam logic [7:0] PFX_SEG_ES = 8'h26;
    localparam logic [7:0] PFX_SEG_CS = 8'h2E;
    localparam logic [7:0] PFX_SEG_SS = 8'h36;
    localparam logic [7:0] PFX_SEG_DS = 8'h3E;
    localparam logic [7:0] PFX_SEG_FS = 8'h64;
    localparam logic [7:0] PFX_SEG_GS = 8'h65;

    // Decoded instruction as presented on the output stream.
    typedef struct packed {
        logic [MAX_BODY_BYTES-1:0][7:0] body;         // Opcode in byte 0, rest zero.
        op_class_e                      op_class;
        logic [3:0]                     body_len;     // Bytes after the prefixes.
        logic [3:0]                     prefix_count;
        logic                           opsize;       // 66h seen.
        logic                           lock;         // F0h seen.
        logic                           rep;          // F2h or F3h seen.
    } insn_t;

    // Legacy prefix test on one byte.
    function automatic logic is_prefix(logic [7:0] b);
        case (b)
            PFX_OPSIZE, PFX_ADSIZE, PFX_LOCK, PFX_REPNE, PFX_REP,
            PFX_SEG_ES, PFX_SEG_CS, PFX_SEG_SS,
            PFX_SEG_DS, PFX_SEG_FS, PFX_SEG_GS:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage
